/* hw/uart_host_pkg.sv */
// shared types for the uart host bridge; addresses and data are fixed at 32 bits
package uart_host_pkg;

	// one serial character
	typedef logic [7:0] byte_t;

	// axi byte address and register word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// axi4-lite response code
	typedef logic [1:0] resp_t;
	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// parser to master, data is zero for reads
	typedef struct packed {
		logic  write;
		addr_t addr;
		data_t data;
	} cmd_t;

	// master to encoder, data is read data or the written word
	typedef struct packed {
		resp_t resp;
		addr_t addr;
		data_t data;
	} rsp_t;

	// frame parser states
	typedef enum logic [1:0] {
		PS_IDLE,
		PS_ADDR,
		PS_DATA
	} parse_state_e;

endpackage

/* hw/uart_rx.sv */
// 8N1 receiver, CLKS_PER_BIT must be at least 4; a low stop bit drops the byte silently
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rxd,
	output uart_host_pkg::byte_t rx_byte,
	output logic                 rx_valid
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	// two-flop synchronizer, idles high
	logic [1:0] rxd_sync;
	logic busy;
	// clocks left until the next sample point
	logic [CW-1:0] clk_cnt;
	// 0 start, 1 to 8 data, 9 stop
	logic [3:0] bit_cnt;

	always_ff @(posedge clk) begin
		rx_valid <= 1'b0;
		if (rst) begin
			rxd_sync <= 2'b11;
			busy     <= 1'b0;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			if (!busy) begin
				// line low while idle means a start edge
				if (!rxd_sync[1]) begin
					busy    <= 1'b1;
					bit_cnt <= '0;
					// first sample lands mid start bit
					clk_cnt <= CW'(CLKS_PER_BIT / 2 - 1);
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= CW'(CLKS_PER_BIT - 1);
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd0) begin
					// glitch, start bit gone high again
					if (rxd_sync[1])
						busy <= 1'b0;
				end else if (bit_cnt == 4'd9) begin
					// stop bit sample, only a high stop bit emits the byte
					busy     <= 1'b0;
					rx_valid <= rxd_sync[1];
				end
			end
		end
	end

	// lsb first, new bit enters at the top
	always_ff @(posedge clk) begin
		if (busy && clk_cnt == '0 && bit_cnt != 4'd0 && bit_cnt != 4'd9)
			rx_byte <= {rxd_sync[1], rx_byte[7:1]};
	end

endmodule

/* hw/hex_cmd_parser.sv */
// decodes W+16 or R+8 upper case hex digit frames; bytes arriving while a command waits are lost
`timescale 1ns/1ps

module hex_cmd_parser (
	input  logic                 clk,
	input  logic                 rst,
	input  uart_host_pkg::byte_t rx_byte,
	input  logic                 rx_valid,
	output uart_host_pkg::cmd_t  cmd,
	output logic                 cmd_valid,
	input  logic                 cmd_ready
);

	// ascii codes used by the frame format
	localparam uart_host_pkg::byte_t CH_0 = 8'h30;
	localparam uart_host_pkg::byte_t CH_9 = 8'h39;
	localparam uart_host_pkg::byte_t CH_A = 8'h41;
	localparam uart_host_pkg::byte_t CH_F = 8'h46;
	localparam uart_host_pkg::byte_t CH_R = 8'h52;
	localparam uart_host_pkg::byte_t CH_W = 8'h57;

	uart_host_pkg::parse_state_e state;
	logic [2:0] digit_cnt;
	logic       is_hex;
	logic [3:0] nib;
	logic       take;

	// a held command blocks the byte stream until it is taken
	assign take = rx_valid && (!cmd_valid || cmd_ready);

	// character to nibble
	always_comb begin
		is_hex = 1'b1;
		nib    = 4'h0;
		if (rx_byte >= CH_0 && rx_byte <= CH_9)
			nib = rx_byte[3:0];
		else if (rx_byte >= CH_A && rx_byte <= CH_F)
			// low nibble of A is 1
			nib = rx_byte[3:0] + 4'd9;
		else
			is_hex = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= uart_host_pkg::PS_IDLE;
			digit_cnt <= '0;
			cmd_valid <= 1'b0;
		end else begin
			if (cmd_valid && cmd_ready)
				cmd_valid <= 1'b0;
			if (take) begin
				case (state)
					uart_host_pkg::PS_IDLE: begin
						// anything other than a start letter is ignored
						if (rx_byte == CH_W || rx_byte == CH_R) begin
							state     <= uart_host_pkg::PS_ADDR;
							digit_cnt <= '0;
						end
					end
					uart_host_pkg::PS_ADDR: begin
						if (!is_hex) begin
							state <= uart_host_pkg::PS_IDLE;
						end else begin
							digit_cnt <= digit_cnt + 1'b1;
							if (digit_cnt == 3'd7) begin
								// reads end after the address
								if (cmd.write) begin
									state <= uart_host_pkg::PS_DATA;
								end else begin
									state     <= uart_host_pkg::PS_IDLE;
									cmd_valid <= 1'b1;
								end
							end
						end
					end
					uart_host_pkg::PS_DATA: begin
						if (!is_hex) begin
							state <= uart_host_pkg::PS_IDLE;
						end else begin
							digit_cnt <= digit_cnt + 1'b1;
							if (digit_cnt == 3'd7) begin
								state     <= uart_host_pkg::PS_IDLE;
								cmd_valid <= 1'b1;
							end
						end
					end
					default: state <= uart_host_pkg::PS_IDLE;
				endcase
			end
		end
	end

	// payload, msb first shifts
	always_ff @(posedge clk) begin
		if (take) begin
			if (state == uart_host_pkg::PS_IDLE) begin
				cmd.write <= (rx_byte == CH_W);
				cmd.data  <= '0;
			end else if (state == uart_host_pkg::PS_ADDR && is_hex) begin
				cmd.addr <= {cmd.addr[27:0], nib};
			end else if (state == uart_host_pkg::PS_DATA && is_hex) begin
				cmd.data <= {cmd.data[27:0], nib};
			end
		end
	end

endmodule

/* hw/axil_cmd_master.sv */
// one outstanding axi4-lite transfer at a time, full word writes only
`timescale 1ns/1ps

module axil_cmd_master (
	input  logic                 clk,
	input  logic                 rst,
	input  uart_host_pkg::cmd_t  cmd,
	input  logic                 cmd_valid,
	output logic                 cmd_ready,
	output uart_host_pkg::addr_t awaddr,
	output logic                 awvalid,
	input  logic                 awready,
	output uart_host_pkg::data_t wdata,
	output logic [3:0]           wstrb,
	output logic                 wvalid,
	input  logic                 wready,
	input  uart_host_pkg::resp_t bresp,
	input  logic                 bvalid,
	output logic                 bready,
	output uart_host_pkg::addr_t araddr,
	output logic                 arvalid,
	input  logic                 arready,
	input  uart_host_pkg::data_t rdata,
	input  uart_host_pkg::resp_t rresp,
	input  logic                 rvalid,
	output logic                 rready,
	output uart_host_pkg::rsp_t  rsp,
	output logic                 rsp_valid,
	input  logic                 rsp_ready
);

	// high from command accept until the response is handed off
	logic busy;

	assign cmd_ready = !busy;
	// rsp holds the address and write word for the whole transfer
	assign awaddr = rsp.addr;
	assign araddr = rsp.addr;
	assign wdata  = rsp.data;
	assign wstrb  = 4'hf;
	// only one transfer in flight, so any response is ours
	assign bready = busy && !rsp_valid;
	assign rready = busy && !rsp_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			arvalid   <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			if (cmd_valid && cmd_ready) begin
				busy    <= 1'b1;
				awvalid <= cmd.write;
				wvalid  <= cmd.write;
				arvalid <= !cmd.write;
			end
			// aw and w may be taken on different clocks
			if (awvalid && awready)
				awvalid <= 1'b0;
			if (wvalid && wready)
				wvalid <= 1'b0;
			if (arvalid && arready)
				arvalid <= 1'b0;
			if ((bvalid && bready) || (rvalid && rready))
				rsp_valid <= 1'b1;
			if (rsp_valid && rsp_ready) begin
				rsp_valid <= 1'b0;
				busy      <= 1'b0;
			end
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready) begin
			rsp.addr <= cmd.addr;
			rsp.data <= cmd.data;
		end
		if (bvalid && bready)
			rsp.resp <= bresp;
		if (rvalid && rready) begin
			rsp.resp <= rresp;
			rsp.data <= rdata;
		end
	end

endmodule

/* hw/reg_bank.sv */
// axi4-lite register file, REG_WORDS at least 2; words past the top answer SLVERR
`timescale 1ns/1ps

module reg_bank #(
	parameter int REG_WORDS = 16
) (
	input  logic                 clk,
	input  logic                 rst,
	input  uart_host_pkg::addr_t awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  uart_host_pkg::data_t wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output uart_host_pkg::resp_t bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  uart_host_pkg::addr_t araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output uart_host_pkg::data_t rdata,
	output uart_host_pkg::resp_t rresp,
	output logic                 rvalid,
	input  logic                 rready
);

	localparam int IW = $clog2(REG_WORDS);

	uart_host_pkg::data_t regs [REG_WORDS];
	logic          wr_hit;
	logic          rd_hit;
	logic [IW-1:0] wr_idx;
	logic [IW-1:0] rd_idx;

	// full word index checked so high address bits do not alias
	assign wr_hit = awaddr[31:2] < REG_WORDS;
	assign rd_hit = araddr[31:2] < REG_WORDS;
	assign wr_idx = awaddr[IW+1:2];
	assign rd_idx = araddr[IW+1:2];

	// aw and w taken together, no new write while b is pending
	assign awready = awvalid && wvalid && !bvalid;
	assign wready  = awready;
	assign arready = arvalid && !rvalid;

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			regs   <= '{default: '0};
		end else begin
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (awready) begin
				bvalid <= 1'b1;
				// byte lanes per strobe
				for (int b = 0; b < 4; b++) begin
					if (wr_hit && wstrb[b])
						regs[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
			if (arready)
				rvalid <= 1'b1;
		end
	end

	// response payload, out of range reads give zero
	always_ff @(posedge clk) begin
		if (awready)
			bresp <= wr_hit ? uart_host_pkg::RESP_OKAY : uart_host_pkg::RESP_SLVERR;
		if (arready) begin
			rresp <= rd_hit ? uart_host_pkg::RESP_OKAY : uart_host_pkg::RESP_SLVERR;
			rdata <= rd_hit ? regs[rd_idx] : '0;
		end
	end

endmodule

/* hw/hex_resp_encoder.sv */
// emits S, resp digit, 8 address and 8 data digits as upper case ascii hex; no line terminator
`timescale 1ns/1ps

module hex_resp_encoder (
	input  logic                 clk,
	input  logic                 rst,
	input  uart_host_pkg::rsp_t  rsp,
	input  logic                 rsp_valid,
	output logic                 rsp_ready,
	output uart_host_pkg::byte_t tx_byte,
	output logic                 tx_valid,
	input  logic                 tx_ready
);

	// ascii codes for the response frame
	localparam uart_host_pkg::byte_t CH_0 = 8'h30;
	localparam uart_host_pkg::byte_t CH_A = 8'h41;
	localparam uart_host_pkg::byte_t CH_S = 8'h53;

	logic busy;
	// character position, 0 is S and 17 the last data digit
	logic [4:0] idx;
	// resp nibble, address, data, top nibble goes out next
	logic [67:0] digits;
	logic [3:0]  nib;

	assign rsp_ready = !busy;
	assign tx_valid  = busy;
	assign nib       = digits[67:64];

	// nibble to ascii
	always_comb begin
		if (idx == 5'd0)
			tx_byte = CH_S;
		else if (nib < 4'd10)
			tx_byte = CH_0 + {4'h0, nib};
		else
			tx_byte = CH_A + {4'h0, nib} - 8'd10;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			idx  <= '0;
		end else if (!busy) begin
			if (rsp_valid) begin
				busy <= 1'b1;
				idx  <= '0;
			end
		end else if (tx_ready) begin
			// rsp_ready comes back only after the last character is taken
			if (idx == 5'd17)
				busy <= 1'b0;
			else
				idx <= idx + 1'b1;
		end
	end

	// latched response, shifted one digit per taken character
	always_ff @(posedge clk) begin
		if (rsp_valid && rsp_ready)
			digits <= {2'b00, rsp.resp, rsp.addr, rsp.data};
		else if (busy && tx_ready && idx != 5'd0)
			digits <= {digits[63:0], 4'h0};
	end

endmodule

/* hw/uart_tx.sv */
// 8N1 transmitter, one byte per valid/ready transfer, no flow control on the line
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  uart_host_pkg::byte_t tx_byte,
	input  logic                 tx_valid,
	output logic                 tx_ready,
	output logic                 txd
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	logic busy;
	// stop, data lsb first, start
	logic [9:0]    frame;
	logic [3:0]    bit_cnt;
	logic [CW-1:0] clk_cnt;

	assign tx_ready = !busy;
	// line idles high
	assign txd = busy ? frame[0] : 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
		end else if (!busy) begin
			if (tx_valid) begin
				busy    <= 1'b1;
				bit_cnt <= '0;
				clk_cnt <= CW'(CLKS_PER_BIT - 1);
			end
		end else if (clk_cnt != '0) begin
			clk_cnt <= clk_cnt - 1'b1;
		end else begin
			clk_cnt <= CW'(CLKS_PER_BIT - 1);
			// ready again once the stop bit has run its full time
			if (bit_cnt == 4'd9)
				busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && tx_valid)
			frame <= {1'b1, tx_byte, 1'b0};
		else if (busy && clk_cnt == '0)
			frame <= {1'b1, frame[9:1]};
	end

endmodule

/* hw/uart_host_top.sv */
// uart hex host bridge; CLKS_PER_BIT is clk over baud rate, at least 4
`timescale 1ns/1ps

module uart_host_top #(
	parameter int CLKS_PER_BIT = 868,
	parameter int REG_WORDS    = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic rxd,
	output logic txd
);

	uart_host_pkg::byte_t rx_byte;
	logic                 rx_valid;
	uart_host_pkg::cmd_t  cmd;
	logic                 cmd_valid;
	logic                 cmd_ready;
	uart_host_pkg::rsp_t  rsp;
	logic                 rsp_valid;
	logic                 rsp_ready;
	uart_host_pkg::byte_t tx_byte;
	logic                 tx_valid;
	logic                 tx_ready;

	// axi4-lite between master and register bank
	uart_host_pkg::addr_t awaddr;
	uart_host_pkg::addr_t araddr;
	uart_host_pkg::data_t wdata;
	uart_host_pkg::data_t rdata;
	uart_host_pkg::resp_t bresp;
	uart_host_pkg::resp_t rresp;
	logic [3:0]           wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx0 (
		.clk, .rst, .rxd, .rx_byte, .rx_valid
	);

	hex_cmd_parser parser0 (
		.clk, .rst, .rx_byte, .rx_valid, .cmd, .cmd_valid, .cmd_ready
	);

	axil_cmd_master master0 (
		.clk, .rst, .cmd, .cmd_valid, .cmd_ready,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.rsp, .rsp_valid, .rsp_ready
	);

	reg_bank #(.REG_WORDS(REG_WORDS)) regs0 (
		.clk, .rst,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready
	);

	hex_resp_encoder encoder0 (
		.clk, .rst, .rsp, .rsp_valid, .rsp_ready, .tx_byte, .tx_valid, .tx_ready
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx0 (
		.clk, .rst, .tx_byte, .tx_valid, .tx_ready, .txd
	);

endmodule

/* dv/tb_uart_host.sv */
// testbench for uart_host_top at 8 clocks per bit; the host waits for each response start
`timescale 1ns/1ps

module tb_uart_host;

	localparam int CLKS_PER_BIT = 8;
	localparam int REG_WORDS    = 16;
	localparam int CLK_NS       = 4;
	localparam int BIT_NS       = CLKS_PER_BIT * CLK_NS;
	localparam int N_RANDOM     = 200;
	// every frame of every test including dropped ones and the final idle gap
	localparam int N_FRAMES     = 16 + 2 + N_RANDOM + 4 + 5 + 5 + 2;
	// worst frame is a 17 char write plus an 18 char response at 10 bits per char
	localparam int TIMEOUT_NS   = 2 * N_FRAMES * 35 * 10 * BIT_NS;

	logic clk;
	logic rst;
	logic rxd;
	logic txd;

	// register model and response queues holding {resp digit, addr, data}
	logic [31:0] model_regs [REG_WORDS];
	logic [67:0] exp_q [$];
	logic [67:0] got_q [$];
	int          valid_count;
	int          got_count;
	int          resp_starts;
	string       test_name;
	integer      seed;

	uart_host_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.REG_WORDS(REG_WORDS)
	) dut0 (
		.clk, .rst, .rxd, .txd
	);

	always #(CLK_NS / 2) clk = ~clk;

	// nibble to upper case ascii digit
	function automatic logic [7:0] hex_char(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		return 8'h41 + {4'h0, nib} - 8'd10;
	endfunction

	// ascii digit to nibble with bit 4 set for anything else
	function automatic logic [4:0] hex_value(input logic [7:0] c);
		logic [7:0] t;
		t = c - 8'h37;
		if (c >= "0" && c <= "9")
			return {1'b0, c[3:0]};
		if (c >= "A" && c <= "F")
			return {1'b0, t[3:0]};
		return 5'h10;
	endfunction

	// one 8N1 character on rxd with bits changing just after a rising edge
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		int i;
		bits = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			#1 rxd = bits[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	// raw characters for broken frames
	task automatic send_chars(input string s);
		int i;
		for (i = 0; i < s.len(); i++)
			send_byte(s[i]);
	endtask

	// updates the model, queues the expected response, then sends the frame
	task automatic send_frame(input logic wr, input logic [31:0] addr, input logic [31:0] data);
		logic        hit;
		logic [1:0]  resp;
		logic [31:0] rdata;
		int i;
		hit  = addr[31:2] < REG_WORDS;
		// SLVERR past the top word
		resp = hit ? 2'd0 : 2'd2;
		if (wr) begin
			if (hit)
				model_regs[addr[31:2]] = data;
			exp_q.push_back({2'b00, resp, addr, data});
		end else begin
			rdata = hit ? model_regs[addr[31:2]] : 32'h0;
			exp_q.push_back({2'b00, resp, addr, rdata});
		end
		valid_count++;
		send_byte(wr ? 8'h57 : 8'h52);
		for (i = 7; i >= 0; i--)
			send_byte(hex_char(addr[4*i +: 4]));
		if (wr) begin
			for (i = 7; i >= 0; i--)
				send_byte(hex_char(data[4*i +: 4]));
		end
	endtask

	// drains the expected queue against the monitor in order
	task automatic check_responses();
		logic [67:0] exp;
		logic [67:0] got;
		while (exp_q.size() != 0) begin
			wait (got_q.size() != 0);
			exp = exp_q.pop_front();
			got = got_q.pop_front();
			assert (got === exp) else begin
				$display("Mismatch %s: expected %h actual %h", test_name, exp, got);
				$display("Testbench failed");
				$fatal(1, "response differs from the model");
			end
		end
	endtask

	task automatic run_frame(input logic wr, input logic [31:0] addr, input logic [31:0] data);
		send_frame(wr, addr, data);
		check_responses();
	endtask

	// one character off txd sampled mid-bit and off the clock edges
	task automatic receive_char(input logic first, output logic [7:0] c);
		int i;
		@(negedge txd);
		if (first)
			resp_starts++;
		#(BIT_NS / 2 + 1);
		for (i = 0; i < 8; i++) begin
			#(BIT_NS);
			c[i] = txd;
		end
		#(BIT_NS);
		assert (txd === 1'b1) else begin
			$display("stop bit on txd was low in test %s", test_name);
			$display("Testbench failed");
			$fatal(1, "framing error on txd");
		end
	endtask

	// response monitor
	initial begin
		logic [7:0]  c;
		logic [67:0] frame;
		logic [4:0]  v;
		int i;
		@(negedge rst);
		forever begin
			receive_char(1'b1, c);
			assert (c === "S") else begin
				$display("Mismatch %s: expected %h actual %h", test_name, 8'h53, c);
				$display("Testbench failed");
				$fatal(1, "response does not start with S");
			end
			frame = '0;
			// resp digit, 8 address digits, 8 data digits
			for (i = 0; i < 17; i++) begin
				receive_char(1'b0, c);
				v = hex_value(c);
				assert (!v[4]) else begin
					$display("response char %h is not a hex digit in test %s", c, test_name);
					$display("Testbench failed");
					$fatal(1, "bad response character");
				end
				frame = {frame[63:0], v[3:0]};
			end
			got_q.push_back(frame);
			got_count++;
		end
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("the DUT did not finish within %0d ns, stuck in test %s", TIMEOUT_NS, test_name);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] d;
		int i;
		int n;
		seed        = 32'hb994;
		clk         = 1'b0;
		rst         = 1'b1;
		rxd         = 1'b1;
		valid_count = 0;
		got_count   = 0;
		resp_starts = 0;
		test_name   = "reset";
		for (i = 0; i < REG_WORDS; i++)
			model_regs[i] = 32'h0;
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;

		// every register reads zero
		test_name = "reset_read";
		for (i = 0; i < REG_WORDS; i++)
			run_frame(1'b0, 32'(i * 4), 32'h0);

		test_name = "write_read";
		run_frame(1'b1, 32'h14, 32'hDEADBEEF);
		run_frame(1'b0, 32'h14, 32'h0);

		// mostly in range with 1 in 8 out of range
		test_name = "random";
		for (i = 0; i < N_RANDOM; i++) begin
			r = $random(seed);
			d = $random(seed);
			if (r[3:1] != 3'd0)
				a = {26'h0, r[11:8], r[13:12]};
			else if (r[14])
				a = $random(seed);
			else
				a = {25'h0, 1'b1, r[11:8], 2'b00};
			run_frame(r[0], a, r[0] ? d : 32'h0);
		end

		test_name = "out_of_range";
		run_frame(1'b1, 32'h40, 32'h12345678);
		run_frame(1'b0, 32'h40, 32'h0);
		run_frame(1'b1, 32'hFFFFFFFC, 32'h87654321);
		run_frame(1'b0, 32'h0, 32'h0);

		// dropped frames give no response
		test_name = "bad_char";
		send_chars("R0000000g");
		send_chars("W0000G0000000000");
		send_chars("W00000004a1b2c3d4");
		// long enough for a wrongly answered frame to finish its response
		#(20 * 10 * BIT_NS);
		assert (got_count == valid_count) else begin
			$display("Mismatch %s: expected %0d actual %0d", test_name, valid_count, got_count);
			$display("Testbench failed");
			$fatal(1, "response count wrong");
		end
		run_frame(1'b0, 32'h8, 32'h0);
		run_frame(1'b0, 32'h4, 32'h0);

		// next frame goes out while the previous response is on the wire
		test_name = "pipelined";
		n = resp_starts;
		send_frame(1'b1, 32'h24, 32'hA5A50F0F);
		wait (resp_starts > n);
		send_frame(1'b0, 32'h24, 32'h0);
		check_responses();
		n = resp_starts;
		send_frame(1'b0, 32'h3C, 32'h0);
		wait (resp_starts > n);
		send_frame(1'b1, 32'h3C, 32'h0BADF00D);
		check_responses();
		run_frame(1'b0, 32'h3C, 32'h0);

		// nothing extra may arrive
		test_name = "idle";
		#(2 * 35 * 10 * BIT_NS);
		assert (got_count == valid_count) else begin
			$display("Mismatch %s: expected %0d actual %0d", test_name, valid_count, got_count);
			$display("Testbench failed");
			$fatal(1, "unexpected response");
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* verilog.f */
hw/uart_host_pkg.sv
hw/uart_rx.sv
hw/hex_cmd_parser.sv
hw/axil_cmd_master.sv
hw/reg_bank.sv
hw/hex_resp_encoder.sv
hw/uart_tx.sv
hw/uart_host_top.sv
dv/tb_uart_host.sv

/* Bender.yml */
package:
  name: uart_host
  authors: []

sources:
  - hw/uart_host_pkg.sv
  - hw/uart_rx.sv
  - hw/hex_cmd_parser.sv
  - hw/axil_cmd_master.sv
  - hw/reg_bank.sv
  - hw/hex_resp_encoder.sv
  - hw/uart_tx.sv
  - hw/uart_host_top.sv
  - target: simulation
    files:
      - dv/tb_uart_host.sv
